// ==== source/vdisp_consts.svh ====
`ifndef VDISP_CONSTS_SVH
`define VDISP_CONSTS_SVH

// Vector register length, in bits and in bytes
`define VDISP_VLEN  128
`define VDISP_VLENB 16

// Widest supported element
`define VDISP_ELEN  64
`define VDISP_ELENB 8

// Scalar word width of the core
`define VDISP_XLEN  64

// Wide enough for the largest VLMAX (128)
`define VDISP_VL_W  8

`endif

// ==== source/rvv_isa_pkg.sv ====
package rvv_isa_pkg;

  // Raw 32-bit instruction word
  typedef logic [31:0] insn_t;

  // Major opcodes seen on the accelerator port
  typedef enum logic [6:0] {
    OP_LOAD_FP  = 7'b0000111,
    OP_STORE_FP = 7'b0100111,
    OP_VEC      = 7'b1010111,
    OP_SYSTEM   = 7'b1110011
  } opcode_e;

  // Operand groups of OP_VEC, in the func3 field
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPFVV = 3'b001,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPFVF = 3'b101,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } vfunc3_e;

  // Vector CSR addresses
  typedef enum logic [11:0] {
    CSR_VSTART = 12'h008,
    CSR_VL     = 12'hC20,
    CSR_VTYPE  = 12'hC21,
    CSR_VLENB  = 12'hC22
  } csr_addr_e;

  // Selected element width
  typedef enum logic [2:0] {
    EW8  = 3'b000,
    EW16 = 3'b001,
    EW32 = 3'b010,
    EW64 = 3'b011
  } vsew_e;

  // Register group multiplier, signed log2 encoding
  typedef enum logic [2:0] {
    LMUL_1    = 3'b000,
    LMUL_2    = 3'b001,
    LMUL_4    = 3'b010,
    LMUL_8    = 3'b011,
    LMUL_RSVD = 3'b100,
    LMUL_1_8  = 3'b101,
    LMUL_1_4  = 3'b110,
    LMUL_1_2  = 3'b111
  } vlmul_e;

endpackage

// ==== source/vdisp_pkg.sv ====
`include "vdisp_consts.svh"

package vdisp_pkg;

  typedef logic [`VDISP_VL_W-1:0] vlen_t;
  typedef logic [4:0]             vreg_t;
  typedef logic [`VDISP_XLEN-1:0] xword_t;

  // Operations understood by the vector backend
  typedef enum logic [3:0] {
    VADD, VSUB, VRSUB,
    VMINU, VMIN, VMAXU, VMAX,
    VAND, VOR, VXOR,
    VMERGE,
    VSLL, VSRL, VSRA
  } vop_e;

  // Coarse instruction class, picks the unit that answers
  typedef enum logic [1:0] {
    KIND_CFG,
    KIND_CSR,
    KIND_ARITH,
    KIND_ILLEGAL
  } insn_kind_e;

  typedef enum logic {
    ST_NORMAL,
    ST_WAIT_IDLE
  } disp_state_e;

endpackage

// ==== source/vcfg_unit.sv ====
`include "vdisp_consts.svh"

module vcfg_unit import rvv_isa_pkg::*; import vdisp_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  insn_t      insn_i,
  input  xword_t     rs1_i,
  input  xword_t     rs2_i,
  input  insn_kind_e kind_i,
  input  logic       accept_i,
  output vlen_t      vl_o,
  output vsew_e      vsew_o,
  output vlmul_e     vlmul_o,
  output logic       vill_o,
  output logic       vtype_change_o,
  output logic       cfg_error_o,
  output xword_t     result_o
);

  localparam int elenb_log = $clog2(`VDISP_ELENB);

  vlen_t  vstart_q;
  vlen_t  vl_q;
  logic   vill_q, vma_q, vta_q;
  vsew_e  vsew_q;
  vlmul_e vlmul_q;
  xword_t vtype_word;

  logic              is_vsetvl, cfg_bad, new_illegal;
  logic [4:0]        rs1_field, rd_field;
  logic [7:0]        vtype_raw;
  vsew_e             new_vsew;
  vlmul_e            new_vlmul;
  logic signed [3:0] lmul_log;
  vlen_t             vlmax;
  logic              cfg_vill, cfg_vma, cfg_vta;
  vsew_e             cfg_vsew;
  vlmul_e            cfg_vlmul;
  vlen_t             cfg_vl;

  logic [2:0] csr_op;
  xword_t     csr_operand;
  logic       ro_write, csr_error, csr_wr_vstart;
  vlen_t      vstart_new;
  xword_t     csr_result;

  assign rs1_field = insn_i[19:15];
  assign rd_field  = insn_i[11:7];

  // Same bit layout as the CSR read value below
  assign vtype_word = {vill_q, {(`VDISP_XLEN-9){1'b0}}, vma_q, vta_q,
                       vlmul_q[2], vsew_q, vlmul_q[1:0]};

  // vsetvli carries vtype in its immediate, vsetvl in rs2
  assign is_vsetvl = insn_i[31];
  assign cfg_bad   = is_vsetvl && (insn_i[30:25] != 6'b000000);
  assign vtype_raw = is_vsetvl ? rs2_i[7:0] : insn_i[27:20];
  assign new_vsew  = vsew_e'(vtype_raw[4:2]);
  assign new_vlmul = vlmul_e'({vtype_raw[5], vtype_raw[1:0]});
  assign lmul_log  = {vtype_raw[5], vtype_raw[5], vtype_raw[1:0]};

  // SEW above ELEN, reserved LMUL, or LMUL below SEW/ELEN
  assign new_illegal = (int'(new_vsew) > elenb_log) || (new_vlmul == LMUL_RSVD) ||
                       (int'(lmul_log) + elenb_log < int'(new_vsew));

  // VLMAX = LMUL * VLEN / SEW
  always_comb begin
    vlmax = vlen_t'(`VDISP_VLENB) >> new_vsew;
    case (new_vlmul)
      LMUL_2:   vlmax = vlmax << 1;
      LMUL_4:   vlmax = vlmax << 2;
      LMUL_8:   vlmax = vlmax << 3;
      LMUL_1_2: vlmax = vlmax >> 1;
      LMUL_1_4: vlmax = vlmax >> 2;
      LMUL_1_8: vlmax = vlmax >> 3;
      default:  vlmax = vlmax;
    endcase
  end

  always_comb begin
    cfg_vill  = 1'b0;
    cfg_vma   = vtype_raw[7];
    cfg_vta   = vtype_raw[6];
    cfg_vsew  = new_vsew;
    cfg_vlmul = new_vlmul;
    if (rs1_field == '0 && rd_field == '0) begin
      cfg_vl = vl_q;
    end else if (rs1_field == '0) begin
      cfg_vl = vlmax;
    end else if (rs1_i > xword_t'(vlmax)) begin
      cfg_vl = vlmax;
    end else begin
      cfg_vl = vlen_t'(rs1_i);
    end
    if (new_illegal) begin
      cfg_vill  = 1'b1;
      cfg_vma   = 1'b0;
      cfg_vta   = 1'b0;
      cfg_vsew  = EW8;
      cfg_vlmul = LMUL_1;
      cfg_vl    = '0;
    end
  end

  assign vtype_change_o = (kind_i == KIND_CFG) && !cfg_bad &&
                          ({cfg_vill, cfg_vma, cfg_vta, cfg_vsew, cfg_vlmul} !=
                           {vill_q, vma_q, vta_q, vsew_q, vlmul_q});

  // Immediate forms take the rs1 field as a zero-extended value
  assign csr_op      = insn_i[14:12];
  assign csr_operand = csr_op[2] ? xword_t'(rs1_field) : rs1_i;
  assign ro_write    = (csr_op[1:0] == 2'b01) || (rs1_field != '0);

  always_comb begin
    csr_error     = 1'b0;
    csr_result    = '0;
    csr_wr_vstart = 1'b0;
    vstart_new    = vstart_q;
    case (csr_op[1:0])
      2'b01:   vstart_new = vlen_t'(csr_operand);
      2'b10:   vstart_new = vstart_q | vlen_t'(csr_operand);
      2'b11:   vstart_new = vstart_q & ~vlen_t'(csr_operand);
      default: csr_error = 1'b1;
    endcase
    case (csr_addr_e'(insn_i[31:20]))
      CSR_VSTART: begin
        csr_result    = xword_t'(vstart_q);
        csr_wr_vstart = !csr_error;
      end
      // Read only, any write attempt fails
      CSR_VL: begin
        csr_result = xword_t'(vl_q);
        csr_error  = csr_error | ro_write;
      end
      CSR_VTYPE: begin
        csr_result = vtype_word;
        csr_error  = csr_error | ro_write;
      end
      CSR_VLENB: begin
        csr_result = xword_t'(`VDISP_VLENB);
        csr_error  = csr_error | ro_write;
      end
      default: csr_error = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vstart_q <= '0;
      vl_q     <= '0;
      vill_q   <= 1'b1;
      vma_q    <= 1'b0;
      vta_q    <= 1'b0;
      vsew_q   <= EW8;
      vlmul_q  <= LMUL_1;
    end else if (accept_i) begin
      if (kind_i == KIND_CFG && !cfg_bad) begin
        vl_q    <= cfg_vl;
        vill_q  <= cfg_vill;
        vma_q   <= cfg_vma;
        vta_q   <= cfg_vta;
        vsew_q  <= cfg_vsew;
        vlmul_q <= cfg_vlmul;
      end
      if (kind_i == KIND_CSR && csr_wr_vstart) begin
        vstart_q <= vstart_new;
      end
    end
  end

  assign vl_o    = vl_q;
  assign vsew_o  = vsew_q;
  assign vlmul_o = vlmul_q;
  assign vill_o  = vill_q;

  assign cfg_error_o = (kind_i == KIND_CFG) ? cfg_bad :
                       (kind_i == KIND_CSR) ? csr_error : 1'b0;
  // Config instructions hand the new vl back to rd
  assign result_o    = (kind_i == KIND_CSR) ? csr_result :
                       (kind_i == KIND_CFG) ? xword_t'(cfg_vl) : '0;

endmodule

// ==== source/varith_decoder.sv ====
module varith_decoder import rvv_isa_pkg::*; import vdisp_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  insn_t      insn_i,
  input  xword_t     rs1_i,
  input  vlen_t      vl_i,
  input  vsew_e      vsew_i,
  input  vlmul_e     vlmul_i,
  input  logic       vill_i,
  input  logic       accept_i,
  input  logic       req_ready_i,
  output insn_kind_e kind_o,
  output logic       arith_error_o,
  output logic       req_valid_o,
  output vop_e       req_op_o,
  output vreg_t      req_vd_o,
  output vreg_t      req_vs1_o,
  output vreg_t      req_vs2_o,
  output logic       req_use_vs1_o,
  output logic       req_use_vs2_o,
  output xword_t     req_scalar_o,
  output logic       req_use_scalar_o,
  output logic       req_vm_o,
  output vlen_t      req_vl_o,
  output vsew_e      req_vsew_o,
  output vlmul_e     req_vlmul_o
);

  opcode_e    opcode;
  vfunc3_e    func3;
  logic [5:0] func6;
  logic       vm;
  vreg_t      vd, vs1, vs2;
  logic       is_opivx;
  vop_e       op;
  logic       op_known;
  logic       use_vs2;
  logic [4:0] align_mask;
  logic       misaligned;
  logic       req_valid_d;

  assign opcode   = opcode_e'(insn_i[6:0]);
  assign func3    = vfunc3_e'(insn_i[14:12]);
  assign func6    = insn_i[31:26];
  assign vm       = insn_i[25];
  assign vs2      = insn_i[24:20];
  assign vs1      = insn_i[19:15];
  assign vd       = insn_i[11:7];
  assign is_opivx = (func3 == OPIVX);

  always_comb begin
    kind_o = KIND_ILLEGAL;
    case (opcode)
      OP_VEC: begin
        case (func3)
          OPCFG:        kind_o = KIND_CFG;
          OPIVV, OPIVX: kind_o = KIND_ARITH;
          default:      kind_o = KIND_ILLEGAL;
        endcase
      end
      OP_SYSTEM: kind_o = KIND_CSR;
      default:   kind_o = KIND_ILLEGAL;
    endcase
  end

  // Shared func6 table for the vector-vector and vector-scalar forms
  always_comb begin
    op       = VADD;
    op_known = 1'b1;
    use_vs2  = 1'b1;
    case (func6)
      6'b000000: op = VADD;
      6'b000010: op = VSUB;
      6'b000011: begin
        // Reverse subtract has no vector-vector form
        op       = VRSUB;
        op_known = is_opivx;
      end
      6'b000100: op = VMINU;
      6'b000101: op = VMIN;
      6'b000110: op = VMAXU;
      6'b000111: op = VMAX;
      6'b001001: op = VAND;
      6'b001010: op = VOR;
      6'b001011: op = VXOR;
      6'b010111: begin
        op      = VMERGE;
        use_vs2 = !vm;  // unmasked form is a plain move
      end
      6'b100101: op = VSLL;
      6'b101000: op = VSRL;
      6'b101001: op = VSRA;
      default:   op_known = 1'b0;
    endcase
  end

  // Register groups must start on an LMUL boundary
  always_comb begin
    case (vlmul_i)
      LMUL_2:  align_mask = 5'b00001;
      LMUL_4:  align_mask = 5'b00011;
      LMUL_8:  align_mask = 5'b00111;
      default: align_mask = 5'b00000;
    endcase
  end

  assign misaligned = (|(vd & align_mask)) || (|(vs2 & align_mask)) ||
                      (!is_opivx && (|(vs1 & align_mask)));

  assign arith_error_o = !op_known || misaligned || vill_i;
  assign req_valid_d   = accept_i && (kind_o == KIND_ARITH) && !arith_error_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_o <= 1'b0;
    end else if (req_ready_i) begin
      req_valid_o <= req_valid_d;
    end
  end

  // Payload follows the valid bit, loaded whenever the backend takes it
  always_ff @(posedge clk_i) begin
    if (req_ready_i) begin
      req_op_o         <= op;
      req_vd_o         <= vd;
      req_vs1_o        <= is_opivx ? vreg_t'(0) : vs1;
      req_vs2_o        <= vs2;
      req_use_vs1_o    <= !is_opivx;
      req_use_vs2_o    <= use_vs2;
      req_scalar_o     <= is_opivx ? rs1_i : xword_t'(0);
      req_use_scalar_o <= is_opivx;
      req_vm_o         <= vm;
      req_vl_o         <= vl_i;
      req_vsew_o       <= vsew_i;
      req_vlmul_o      <= vlmul_i;
    end
  end

endmodule

// ==== source/issue_fsm.sv ====
module issue_fsm import vdisp_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       acc_req_valid_i,
  input  logic       acc_resp_ready_i,
  input  logic       req_ready_i,
  input  logic       backend_idle_i,
  input  insn_kind_e kind_i,
  input  logic       vtype_change_i,
  input  logic       cfg_error_i,
  input  logic       arith_error_i,
  output logic       accept_o,
  output logic       acc_req_ready_o,
  output logic       acc_resp_valid_o,
  output logic       acc_resp_error_o
);

  disp_state_e state_q, state_d;
  logic        can_issue;
  logic        accept;

  // An idle backend releases the wait in the same cycle
  assign can_issue = (state_q == ST_NORMAL) || backend_idle_i;

  // Only arithmetic needs room in the backend request register
  assign accept = acc_req_valid_i && acc_resp_ready_i && can_issue &&
                  ((kind_i != KIND_ARITH) || req_ready_i);

  assign accept_o         = accept;
  assign acc_req_ready_o  = accept;
  assign acc_resp_valid_o = accept;

  always_comb begin
    case (kind_i)
      KIND_ILLEGAL: acc_resp_error_o = 1'b1;
      KIND_ARITH:   acc_resp_error_o = arith_error_i;
      default:      acc_resp_error_o = cfg_error_i;
    endcase
  end

  always_comb begin
    state_d = state_q;
    if (accept && kind_i == KIND_CFG && vtype_change_i) begin
      state_d = ST_WAIT_IDLE;
    end else if (state_q == ST_WAIT_IDLE && backend_idle_i) begin
      state_d = ST_NORMAL;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_NORMAL;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== source/vec_dispatcher.sv ====
module vec_dispatcher import rvv_isa_pkg::*; import vdisp_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  // Core side
  input  insn_t  acc_insn_i,
  input  xword_t acc_rs1_i,
  input  xword_t acc_rs2_i,
  input  logic   acc_req_valid_i,
  output logic   acc_req_ready_o,
  output logic   acc_resp_valid_o,
  output xword_t acc_resp_result_o,
  output logic   acc_resp_error_o,
  input  logic   acc_resp_ready_i,
  // Backend side
  output logic   req_valid_o,
  output vop_e   req_op_o,
  output vreg_t  req_vd_o,
  output vreg_t  req_vs1_o,
  output vreg_t  req_vs2_o,
  output logic   req_use_vs1_o,
  output logic   req_use_vs2_o,
  output xword_t req_scalar_o,
  output logic   req_use_scalar_o,
  output logic   req_vm_o,
  output vlen_t  req_vl_o,
  output vsew_e  req_vsew_o,
  output vlmul_e req_vlmul_o,
  input  logic   req_ready_i,
  input  logic   backend_idle_i
);

  insn_kind_e kind;
  logic       accept;
  logic       vtype_change;
  logic       cfg_error;
  logic       arith_error;
  vlen_t      vl;
  vsew_e      vsew;
  vlmul_e     vlmul;
  logic       vill;

  // Architectural vector state and CSR answers
  vcfg_unit vcfg_unit_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insn_i         (acc_insn_i),
    .rs1_i          (acc_rs1_i),
    .rs2_i          (acc_rs2_i),
    .kind_i         (kind),
    .accept_i       (accept),
    .vl_o           (vl),
    .vsew_o         (vsew),
    .vlmul_o        (vlmul),
    .vill_o         (vill),
    .vtype_change_o (vtype_change),
    .cfg_error_o    (cfg_error),
    .result_o       (acc_resp_result_o)
  );

  varith_decoder varith_decoder_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .insn_i           (acc_insn_i),
    .rs1_i            (acc_rs1_i),
    .vl_i             (vl),
    .vsew_i           (vsew),
    .vlmul_i          (vlmul),
    .vill_i           (vill),
    .accept_i         (accept),
    .req_ready_i      (req_ready_i),
    .kind_o           (kind),
    .arith_error_o    (arith_error),
    .req_valid_o      (req_valid_o),
    .req_op_o         (req_op_o),
    .req_vd_o         (req_vd_o),
    .req_vs1_o        (req_vs1_o),
    .req_vs2_o        (req_vs2_o),
    .req_use_vs1_o    (req_use_vs1_o),
    .req_use_vs2_o    (req_use_vs2_o),
    .req_scalar_o     (req_scalar_o),
    .req_use_scalar_o (req_use_scalar_o),
    .req_vm_o         (req_vm_o),
    .req_vl_o         (req_vl_o),
    .req_vsew_o       (req_vsew_o),
    .req_vlmul_o      (req_vlmul_o)
  );

  issue_fsm issue_fsm_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .acc_req_valid_i  (acc_req_valid_i),
    .acc_resp_ready_i (acc_resp_ready_i),
    .req_ready_i      (req_ready_i),
    .backend_idle_i   (backend_idle_i),
    .kind_i           (kind),
    .vtype_change_i   (vtype_change),
    .cfg_error_i      (cfg_error),
    .arith_error_i    (arith_error),
    .accept_o         (accept),
    .acc_req_ready_o  (acc_req_ready_o),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_error_o (acc_resp_error_o)
  );

endmodule

// ==== dv/vdisp_clk_gen.sv ====
module vdisp_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // Period of 8 time units
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held low for the first two cycles
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== dv/vec_dispatcher_tb.sv ====
`include "vdisp_consts.svh"

module vec_dispatcher_tb import rvv_isa_pkg::*; import vdisp_pkg::*; ();

  localparam int N_INSN   = 160;
  localparam int WATCHDOG = (N_INSN * 40 + 100) * 8;

  typedef struct packed {
    vop_e   op;
    vreg_t  vd;
    vreg_t  vs1;
    vreg_t  vs2;
    logic   use_vs1;
    logic   use_vs2;
    xword_t scalar;
    logic   use_scalar;
    logic   vm;
    vlen_t  vl;
    vsew_e  vsew;
    vlmul_e vlmul;
  } req_s;

  logic   clk_i, rst_ni;
  insn_t  acc_insn_i;
  xword_t acc_rs1_i, acc_rs2_i;
  logic   acc_req_valid_i, acc_resp_ready_i, req_ready_i, backend_idle_i;
  logic   acc_req_ready_o, acc_resp_valid_o, acc_resp_error_o;
  xword_t acc_resp_result_o;
  logic   req_valid_o, req_use_vs1_o, req_use_vs2_o, req_use_scalar_o, req_vm_o;
  vop_e   req_op_o;
  vreg_t  req_vd_o, req_vs1_o, req_vs2_o;
  xword_t req_scalar_o;
  vlen_t  req_vl_o;
  vsew_e  req_vsew_o;
  vlmul_e req_vlmul_o;

  // Reference state kept by the testbench
  logic [31:0] lfsr = 32'h10b2;
  vlen_t       vl_m, vstart_m;
  logic        vill_m;
  logic [7:0]  vt_m;
  logic        exp_err, chk_res, exp_block, exp_req_valid;
  xword_t      exp_res;
  req_s        exp_req, pend_req;
  int          errors = 0;
  int          hs_errors = 0;
  int          last_cycles;

  vdisp_clk_gen clk_gen_i (.clk_o(clk_i), .rst_no(rst_ni));

  vec_dispatcher vec_dispatcher_i (.*);

  a_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_resp_valid_o |-> (acc_resp_error_o == exp_err &&
                          (!chk_res || acc_resp_result_o == exp_res)))
    else begin
      errors++;
      $display("ERROR %0t: response mismatch, expected error %0b result %h",
               $time, exp_err, exp_res);
    end

  // A response comes exactly with an accepted request
  a_resp_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_resp_valid_o == (acc_req_valid_i && acc_req_ready_o))
    else begin
      errors++;
      $display("ERROR %0t: response valid does not match the accept handshake", $time);
    end

  a_block: assert property (@(posedge clk_i) disable iff (!rst_ni)
    exp_block |-> !acc_req_ready_o)
    else begin
      errors++;
      $display("ERROR %0t: instruction accepted while it should stall", $time);
    end

  a_req_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_o == exp_req_valid)
    else begin
      errors++;
      $display("ERROR %0t: req_valid_o differs, expected %0b", $time, exp_req_valid);
    end

  a_req_fields: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_o |-> ({req_op_o, req_vd_o, req_vs1_o, req_vs2_o, req_use_vs1_o,
                      req_use_vs2_o, req_scalar_o, req_use_scalar_o, req_vm_o,
                      req_vl_o, req_vsew_o, req_vlmul_o} == exp_req))
    else begin
      errors++;
      $display("ERROR %0t: backend request fields differ, expected %h", $time, exp_req);
    end

  // Galois LFSR stepped once per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        b;
    v = '0;
    for (int k = 0; k < n; k++) begin
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 32'hA300_0000;
      v = {v[62:0], b};
    end
    return v;
  endfunction

  function automatic int lmul_log(input logic [2:0] lmul);
    return (lmul < 3'd4) ? int'(lmul) : int'(lmul) - 8;
  endfunction

  function automatic logic legal_vtype(input logic [7:0] raw);
    logic [2:0] lmul;
    lmul = {raw[5], raw[1:0]};
    return (raw[4:2] <= 3'd3) && (lmul != 3'd4) && (lmul_log(lmul) >= int'(raw[4:2]) - 3);
  endfunction

  // LMUL * VLEN / SEW
  function automatic int vlmax_of(input logic [7:0] raw);
    int base;
    int l;
    base = `VDISP_VLENB >> raw[4:2];
    l = lmul_log({raw[5], raw[1:0]});
    return (l >= 0) ? (base << l) : (base >> (-l));
  endfunction

  function automatic xword_t vtype_word();
    return {vill_m, 55'b0, vt_m};
  endfunction

  function automatic insn_t arith_insn(input logic opivx, input logic [5:0] f6,
                                       input logic vm, input vreg_t vd, vs1, vs2);
    return {f6, vm, vs2, vs1, (opivx ? 3'b100 : 3'b000), vd, 7'b1010111};
  endfunction

  function automatic insn_t csr_insn(input logic [2:0] f3, input logic [11:0] addr,
                                     input logic [4:0] rs1f);
    return {addr, rs1f, f3, 5'd1, 7'b1110011};
  endfunction

  // Codes 1 and 63 are not defined
  function automatic logic [5:0] pick_func6(input logic [3:0] idx);
    logic [5:0] tab [16];
    tab = '{6'd0, 6'd2, 6'd3, 6'd4, 6'd5, 6'd6, 6'd7, 6'd9,
            6'd10, 6'd11, 6'd23, 6'd37, 6'd40, 6'd41, 6'd1, 6'd63};
    return tab[idx];
  endfunction

  // One clock from falling edge to falling edge
  task automatic step(input logic take);
    @(posedge clk_i);
    if (req_ready_i) begin
      exp_req_valid = take;
      if (take) exp_req = pend_req;
    end
    @(negedge clk_i);
  endtask

  task automatic issue(input insn_t insn, input xword_t rs1, input xword_t rs2,
                       input logic err, input xword_t res, input logic chk,
                       input logic arith_ok);
    int   n;
    logic done;
    acc_insn_i      = insn;
    acc_rs1_i       = rs1;
    acc_rs2_i       = rs2;
    acc_req_valid_i = 1'b1;
    exp_err         = err;
    exp_res         = res;
    chk_res         = chk;
    done = 1'b0;
    n    = 0;
    while (!done && n < 40) begin
      #3;
      done = acc_req_ready_o;
      step(done && arith_ok);
      n++;
    end
    acc_req_valid_i = 1'b0;
    chk_res         = 1'b0;
    last_cycles     = n;
    if (!done) begin
      hs_errors++;
      $display("Instruction %h was never accepted by the dispatcher", insn);
    end
  endtask

  task automatic blocked(input insn_t insn, input int n);
    acc_insn_i      = insn;
    acc_req_valid_i = 1'b1;
    exp_block       = 1'b1;
    repeat (n) step(1'b0);
    acc_req_valid_i = 1'b0;
    exp_block       = 1'b0;
  endtask

  task automatic config_vtype(input logic use_vsetvl, input vreg_t rd, input vreg_t rs1f,
                              input xword_t avl, input logic [7:0] raw);
    insn_t insn;
    logic  legal;
    int    vmax;
    vlen_t nvl;
    legal = legal_vtype(raw);
    vmax  = legal ? vlmax_of(raw) : 0;
    if (!legal) nvl = '0;
    else if (rs1f == 0 && rd == 0) nvl = vl_m;
    else if (rs1f == 0) nvl = vlen_t'(vmax);
    else if (avl > xword_t'(vmax)) nvl = vlen_t'(vmax);
    else nvl = vlen_t'(avl);
    if (use_vsetvl) insn = {7'b1000000, 5'd7, rs1f, 3'b111, rd, 7'b1010111};
    else insn = {4'b0000, raw, rs1f, 3'b111, rd, 7'b1010111};
    issue(insn, avl, xword_t'(raw), 1'b0, xword_t'(nvl), 1'b1, 1'b0);
    vl_m   = nvl;
    vill_m = !legal;
    vt_m   = legal ? raw : 8'h00;
  endtask

  task automatic access_csr(input logic [2:0] f3, input logic [11:0] addr,
                            input vreg_t rs1f, input xword_t val, input logic err,
                            input xword_t res);
    issue(csr_insn(f3, addr, rs1f), val, '0, err, res, !err, 1'b0);
  endtask

  task automatic read_csr(input logic [11:0] addr, input xword_t res);
    access_csr(3'b010, addr, 5'd0, '0, 1'b0, res);
  endtask

  task automatic vstart_op(input logic [2:0] f3, input vreg_t rs1f, input xword_t val);
    vlen_t opnd;
    opnd = f3[2] ? vlen_t'(rs1f) : vlen_t'(val);
    access_csr(f3, 12'h008, rs1f, val, 1'b0, xword_t'(vstart_m));
    case (f3[1:0])
      2'b01:   vstart_m = opnd;
      2'b10:   vstart_m = vstart_m | opnd;
      default: vstart_m = vstart_m & ~opnd;
    endcase
  endtask

  task automatic send_arith(input logic opivx, input logic [5:0] f6, input logic vm,
                            input vreg_t vd, input vreg_t vs1, input vreg_t vs2,
                            input xword_t scalar);
    logic       known, use2, mis, err;
    logic [4:0] mask;
    vop_e       op;
    known = 1'b1;
    use2  = 1'b1;
    op    = VADD;
    case (f6)
      6'd0:    op = VADD;
      6'd2:    op = VSUB;
      6'd3: begin
        op    = VRSUB;
        known = opivx;
      end
      6'd4:    op = VMINU;
      6'd5:    op = VMIN;
      6'd6:    op = VMAXU;
      6'd7:    op = VMAX;
      6'd9:    op = VAND;
      6'd10:   op = VOR;
      6'd11:   op = VXOR;
      6'd23: begin
        op   = VMERGE;
        use2 = !vm;
      end
      6'd37:   op = VSLL;
      6'd40:   op = VSRL;
      6'd41:   op = VSRA;
      default: known = 1'b0;
    endcase
    case ({vt_m[5], vt_m[1:0]})
      3'd1:    mask = 5'd1;
      3'd2:    mask = 5'd3;
      3'd3:    mask = 5'd7;
      default: mask = 5'd0;
    endcase
    mis = (|(vd & mask)) || (|(vs2 & mask)) || (!opivx && (|(vs1 & mask)));
    err = !known || mis || vill_m;
    pend_req.op         = op;
    pend_req.vd         = vd;
    pend_req.vs1        = opivx ? vreg_t'(0) : vs1;
    pend_req.vs2        = vs2;
    pend_req.use_vs1    = !opivx;
    pend_req.use_vs2    = use2;
    pend_req.scalar     = opivx ? scalar : xword_t'(0);
    pend_req.use_scalar = opivx;
    pend_req.vm         = vm;
    pend_req.vl         = vl_m;
    pend_req.vsew       = vsew_e'(vt_m[4:2]);
    pend_req.vlmul      = vlmul_e'({vt_m[5], vt_m[1:0]});
    issue(arith_insn(opivx, f6, vm, vd, vs1, vs2), scalar, '0, err, '0, 1'b0, !err);
  endtask

  initial begin
    #(WATCHDOG);
    $display("Watchdog expired before all instructions completed");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    logic [7:0]  raw;
    vreg_t       rd, rs1f;
    logic [63:0] r;
    acc_insn_i       = '0;
    acc_rs1_i        = '0;
    acc_rs2_i        = '0;
    acc_req_valid_i  = 1'b0;
    acc_resp_ready_i = 1'b1;
    req_ready_i      = 1'b1;
    backend_idle_i   = 1'b1;
    exp_err = 1'b0;
    exp_res = '0;
    chk_res = 1'b0;
    exp_block = 1'b0;
    exp_req_valid = 1'b0;
    exp_req = '0;
    pend_req = '0;
    vl_m = '0;
    vstart_m = '0;
    vill_m = 1'b1;
    vt_m = 8'h00;
    @(posedge rst_ni);
    @(negedge clk_i);

    read_csr(CSR_VTYPE, vtype_word());
    read_csr(CSR_VL, '0);

    // Random legal configurations, CSR reads and arithmetic
    for (int i = 0; i < 12; i++) begin
      do begin
        raw = 8'(rand_bits(8));
        raw[4] = 1'b0;
      end while (!legal_vtype(raw));
      rd   = vreg_t'(rand_bits(5));
      rs1f = vreg_t'(rand_bits(5));
      if (i % 4 == 1) begin
        rd   = '0;
        rs1f = '0;
      end else if (i % 4 == 2) begin
        rs1f = '0;
        if (rd == 0) rd = 5'd1;
      end else if (rs1f == 0) begin
        rs1f = 5'd1;
      end
      r = rand_bits(9);
      config_vtype(r[8], rd, rs1f, xword_t'(r[7:0]), raw);
      read_csr(CSR_VL, xword_t'(vl_m));
      read_csr(CSR_VTYPE, vtype_word());
      read_csr(CSR_VLENB, xword_t'(`VDISP_VLENB));
      repeat (3) begin
        r = rand_bits(21);
        send_arith(r[20], pick_func6(r[19:16]), r[15], r[14:10], r[9:5], r[4:0],
                   rand_bits(64));
      end
    end

    // Illegal vtype from SEW 64 at LMUL 1/8 and from the reserved LMUL
    config_vtype(1'b0, 5'd1, 5'd2, 64'd9, 8'b00_1_011_01);
    read_csr(CSR_VTYPE, vtype_word());
    read_csr(CSR_VL, '0);
    send_arith(1'b0, 6'd0, 1'b1, 5'd2, 5'd4, 5'd6, '0);
    config_vtype(1'b1, 5'd1, 5'd2, 64'd20, 8'b00_1_000_00);
    read_csr(CSR_VTYPE, vtype_word());
    config_vtype(1'b0, 5'd1, 5'd2, 64'd5, 8'b00_0_010_01);
    read_csr(CSR_VL, xword_t'(vl_m));

    // vstart access in register and immediate forms
    vstart_op(3'b001, 5'd3, 64'h5a);
    vstart_op(3'b110, 5'd3, '0);
    vstart_op(3'b111, 5'd8, '0);
    vstart_op(3'b010, 5'd4, 64'h81);
    vstart_op(3'b011, 5'd4, 64'h0f);
    vstart_op(3'b101, 5'd17, '0);
    read_csr(CSR_VSTART, xword_t'(vstart_m));
    access_csr(3'b010, CSR_VL, 5'd1, 64'd1, 1'b1, '0);
    access_csr(3'b001, CSR_VTYPE, 5'd2, '0, 1'b1, '0);
    access_csr(3'b011, CSR_VLENB, 5'd1, 64'd1, 1'b1, '0);
    access_csr(3'b010, 12'h123, 5'd0, '0, 1'b1, '0);
    issue(32'h0000_0033, '0, '0, 1'b1, '0, 1'b0, 1'b0);

    // A vtype change holds every kind until the backend is idle
    backend_idle_i = 1'b0;
    config_vtype(1'b0, 5'd1, 5'd3, 64'd100, 8'b01_0_001_10);
    blocked(csr_insn(3'b010, CSR_VL, 5'd0), 3);
    blocked(arith_insn(1'b0, 6'd0, 1'b1, 5'd4, 5'd8, 5'd12), 2);
    blocked({4'b0000, vt_m, 5'd0, 3'b111, 5'd0, 7'b1010111}, 2);
    backend_idle_i = 1'b1;
    read_csr(CSR_VTYPE, vtype_word());
    assert (last_cycles == 1) else begin
      errors++;
      $display("ERROR %0t: waiting instruction not accepted once idle", $time);
    end
    backend_idle_i = 1'b0;
    config_vtype(1'b0, 5'd0, 5'd0, '0, vt_m);
    read_csr(CSR_VL, xword_t'(vl_m));
    assert (last_cycles == 1) else begin
      errors++;
      $display("ERROR %0t: unchanged vtype caused a wait", $time);
    end
    backend_idle_i = 1'b1;

    // Back-pressure from the backend and from the core
    send_arith(1'b0, 6'd0, 1'b1, 5'd8, 5'd4, 5'd12, '0);
    req_ready_i = 1'b0;
    blocked(arith_insn(1'b1, 6'd2, 1'b1, 5'd4, 5'd1, 5'd8), 3);
    read_csr(CSR_VL, xword_t'(vl_m));
    req_ready_i = 1'b1;
    step(1'b0);
    acc_resp_ready_i = 1'b0;
    blocked(csr_insn(3'b010, CSR_VL, 5'd0), 2);
    acc_resp_ready_i = 1'b1;
    repeat (2) step(1'b0);

    $display("Summary: %0d check errors, %0d handshake errors", errors, hs_errors);
    if (errors == 0 && hs_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+source
source/rvv_isa_pkg.sv
source/vdisp_pkg.sv
source/vcfg_unit.sv
source/varith_decoder.sv
source/issue_fsm.sv
source/vec_dispatcher.sv
dv/vdisp_clk_gen.sv
dv/vec_dispatcher_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the dispatcher testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module vec_dispatcher_tb -o sim
if [ $? -ne 0 ]; then
  echo "Compilation failed"
  exit 1
fi

out=$(./obj_dir/sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
echo "Pass message not found"
exit 1
